// ==== Makefile ====
# Verilator build and run for the systolic array testbench

VERILATOR ?= verilator
TOP       ?= tb_sa_top
RTL_TOP   ?= sa_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timescale 1ns/1ps

RTL_SRCS = design/sa_pkg.sv design/sa_ctrl.sv design/sa_pe_row.sv \
           design/sa_transfer_mux.sv design/sa_column_adder.sv design/sa_top.sv

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) sim/tb_sa_top.sv design/sa_defs.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+design $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/sa_column_adder.sv ====
`timescale 1ns/1ps
`include "sa_defs.svh"

module sa_column_adder
        import sa_pkg::*;
(
        input  logic  clk_i,
        input  logic  rst_n_i,
        input  logic  cfg_ld_i,
        input  logic  sum_en_i,
        input  logic  row_en_i [`SA_ROWS],
        input  prod_t tr_i [`SA_ROWS][`SA_COLS],
        output acc_t  result_o [`SA_COLS]
);

        logic row_en_q [`SA_ROWS];
        acc_t node [`SA_ROWS][`SA_COLS];

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        for (int r = 0; r < `SA_ROWS; r++) begin
                                row_en_q[r] <= 1'b0;
                        end
                end else if (cfg_ld_i) begin
                        for (int r = 0; r < `SA_ROWS; r++) begin
                                row_en_q[r] <= row_en_i[r];
                        end
                end
        end

        ////////////////////
        // vertical nodes
        ////////////////////

        // each node adds its row's term to the sum from above
        genvar r, c;
        generate
                for (c = 0; c < `SA_COLS; c = c + 1) begin : g_col
                        for (r = 0; r < `SA_ROWS; r = r + 1) begin : g_row
                                acc_t term;

                                // sign extended product, dropped for a disabled row
                                assign term = row_en_q[r] ? acc_t'(tr_i[r][c]) : '0;

                                if (r == 0) begin : g_top
                                        assign node[r][c] = term;
                                end else begin : g_below
                                        assign node[r][c] = node[r-1][c] + term;
                                end
                        end
                end
        endgenerate

        // bottom node of each column is the result
        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        for (int k = 0; k < `SA_COLS; k++) begin
                                result_o[k] <= '0;
                        end
                end else if (sum_en_i) begin
                        for (int k = 0; k < `SA_COLS; k++) begin
                                result_o[k] <= node[`SA_ROWS-1][k];
                        end
                end
        end

endmodule

// ==== design/sa_ctrl.sv ====
`timescale 1ns/1ps
`include "sa_defs.svh"

module sa_ctrl
        import sa_pkg::*;
(
        input  logic clk_i,
        input  logic rst_n_i,
        input  logic load_i,
        input  logic start_op_i,
        input  logic feature_valid_i,
        output logic w_shift_o,
        output logic prod_en_o,
        output logic cfg_ld_o,
        output logic sum_en_o,
        output logic result_valid_o,
        output logic weights_ready_o
);

        // count value seen just before the last load of a set
        localparam load_cnt_t LAST_LOAD = load_cnt_t'(`SA_COLS - 1);

        sa_state_e state_q;
        sa_state_e state_d;
        load_cnt_t load_cnt_q;
        load_cnt_t load_cnt_d;

        ////////////////////
        // acceptance strobes
        ////////////////////

        // every load shifts the weight chains
        assign w_shift_o = load_i;

        // a load in the same cycle takes priority over start
        assign cfg_ld_o = start_op_i && !load_i && (state_q == SA_READY);

        // features only count while running
        assign prod_en_o = feature_valid_i && (state_q == SA_RUN);

        assign weights_ready_o = (state_q == SA_READY) || (state_q == SA_RUN);

        ////////////////////
        // state machine
        ////////////////////

        always_comb begin
                state_d    = state_q;
                load_cnt_d = load_cnt_q;
                if (load_i) begin
                        if (state_q == SA_LOAD) begin
                                load_cnt_d = load_cnt_q + 1'b1;
                                if (load_cnt_q == LAST_LOAD) begin
                                        state_d = SA_READY;
                                end
                        end else begin
                                // new weight set, a run in progress is dropped
                                load_cnt_d = load_cnt_t'(1);
                                state_d    = (LAST_LOAD == '0) ? SA_READY : SA_LOAD;
                        end
                end else if (cfg_ld_o) begin
                        state_d = SA_RUN;
                end
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        state_q    <= SA_IDLE;
                        load_cnt_q <= '0;
                end else begin
                        state_q    <= state_d;
                        load_cnt_q <= load_cnt_d;
                end
        end

        ////////////////////
        // valid pipeline
        ////////////////////

        // product stage, then sum stage, then result pulse
        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        sum_en_o       <= 1'b0;
                        result_valid_o <= 1'b0;
                end else begin
                        sum_en_o       <= prod_en_o;
                        result_valid_o <= sum_en_o;
                end
        end

endmodule

// ==== design/sa_defs.svh ====
`ifndef SA_DEFS_SVH
`define SA_DEFS_SVH

////////////////////
// array geometry
////////////////////

`define SA_ROWS 4
`define SA_COLS 4

////////////////////
// data widths
////////////////////

`define SA_I_W 8
`define SA_F_W 8
// longest transfer distance plus one
`define SA_LEN_TR 4
`define SA_TR_SEL_W 2
// room for four full-scale products
`define SA_ACC_W 18
`define SA_LOAD_CNT_W 3

`endif

// ==== design/sa_pe_row.sv ====
`timescale 1ns/1ps
`include "sa_defs.svh"

module sa_pe_row
        import sa_pkg::*;
(
        input  logic     clk_i,
        input  logic     rst_n_i,
        input  logic     w_shift_i,
        input  logic     prod_en_i,
        input  weight_t  weight_i,
        input  feature_t feature_i,
        output prod_t    prod_o [`SA_COLS]
);

        weight_t w_q [`SA_COLS];

        ////////////////////
        // weight shift chain
        ////////////////////

        // new weight enters column 0, older ones move right
        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        for (int c = 0; c < `SA_COLS; c++) begin
                                w_q[c] <= '0;
                        end
                end else if (w_shift_i) begin
                        w_q[0] <= weight_i;
                        for (int c = 1; c < `SA_COLS; c++) begin
                                w_q[c] <= w_q[c-1];
                        end
                end
        end

        ////////////////////
        // multipliers
        ////////////////////

        // feature is broadcast along the row
        // products hold when no feature arrives
        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        for (int c = 0; c < `SA_COLS; c++) begin
                                prod_o[c] <= '0;
                        end
                end else if (prod_en_i) begin
                        for (int c = 0; c < `SA_COLS; c++) begin
                                prod_o[c] <= w_q[c] * feature_i;
                        end
                end
        end

endmodule

// ==== design/sa_pkg.sv ====
`include "sa_defs.svh"

package sa_pkg;

        // operand types
        typedef logic signed [`SA_I_W-1:0] feature_t;
        typedef logic signed [`SA_F_W-1:0] weight_t;

        // full product of one element
        typedef logic signed [`SA_I_W+`SA_F_W-1:0] prod_t;

        // column sum, wider than a product
        typedef logic signed [`SA_ACC_W-1:0] acc_t;

        typedef logic [`SA_TR_SEL_W-1:0] tr_sel_t;
        typedef logic [`SA_LOAD_CNT_W-1:0] load_cnt_t;

        // control FSM states
        typedef enum logic [1:0] {
                SA_IDLE,
                SA_LOAD,
                SA_READY,
                SA_RUN
        } sa_state_e;

endpackage

// ==== design/sa_top.sv ====
`timescale 1ns/1ps
`include "sa_defs.svh"

module sa_top
        import sa_pkg::*;
(
        input  logic     clk_i,
        input  logic     rst_n_i,

        // weight loading
        input  logic     load_i,
        input  weight_t  weight_i [`SA_ROWS],

        // run configuration
        input  logic     start_op_i,
        input  tr_sel_t  tr_sel_i [`SA_ROWS],
        input  logic     row_en_i [`SA_ROWS],

        // feature stream
        input  logic     feature_valid_i,
        input  feature_t feature_i [`SA_ROWS],

        output logic     weights_ready_o,
        output logic     result_valid_o,
        output acc_t     result_o [`SA_COLS]
);

        logic w_shift;
        logic prod_en;
        logic cfg_ld;
        logic sum_en;

        // products straight from the elements
        prod_t prod [`SA_ROWS][`SA_COLS];
        // products after the transfer selectors
        prod_t tr [`SA_ROWS][`SA_COLS];

        ////////////////////
        // control
        ////////////////////

        sa_ctrl u_ctrl (
                .clk_i           (clk_i),
                .rst_n_i         (rst_n_i),
                .load_i          (load_i),
                .start_op_i      (start_op_i),
                .feature_valid_i (feature_valid_i),
                .w_shift_o       (w_shift),
                .prod_en_o       (prod_en),
                .cfg_ld_o        (cfg_ld),
                .sum_en_o        (sum_en),
                .result_valid_o  (result_valid_o),
                .weights_ready_o (weights_ready_o)
        );

        ////////////////////
        // array rows
        ////////////////////

        genvar r;
        generate
                for (r = 0; r < `SA_ROWS; r = r + 1) begin : g_row
                        sa_pe_row u_pe_row (
                                .clk_i     (clk_i),
                                .rst_n_i   (rst_n_i),
                                .w_shift_i (w_shift),
                                .prod_en_i (prod_en),
                                .weight_i  (weight_i[r]),
                                .feature_i (feature_i[r]),
                                .prod_o    (prod[r])
                        );

                        sa_transfer_mux u_tr_mux (
                                .clk_i    (clk_i),
                                .rst_n_i  (rst_n_i),
                                .cfg_ld_i (cfg_ld),
                                .tr_sel_i (tr_sel_i[r]),
                                .prod_i   (prod[r]),
                                .tr_o     (tr[r])
                        );
                end
        endgenerate

        // sums all rows per column
        sa_column_adder u_col_add (
                .clk_i    (clk_i),
                .rst_n_i  (rst_n_i),
                .cfg_ld_i (cfg_ld),
                .sum_en_i (sum_en),
                .row_en_i (row_en_i),
                .tr_i     (tr),
                .result_o (result_o)
        );

endmodule

// ==== design/sa_transfer_mux.sv ====
`timescale 1ns/1ps
`include "sa_defs.svh"

module sa_transfer_mux
        import sa_pkg::*;
(
        input  logic    clk_i,
        input  logic    rst_n_i,
        input  logic    cfg_ld_i,
        input  tr_sel_t tr_sel_i,
        input  prod_t   prod_i [`SA_COLS],
        output prod_t   tr_o [`SA_COLS]
);

        // transfer distance k for this row
        tr_sel_t tr_sel_q;

        always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        tr_sel_q <= '0;
                end else if (cfg_ld_i) begin
                        tr_sel_q <= tr_sel_i;
                end
        end

        ////////////////////
        // column selectors
        ////////////////////

        // column c takes the product of column c-k
        // left columns see fewer sources, zero when k > c
        genvar c;
        generate
                for (c = 0; c < `SA_COLS; c = c + 1) begin : g_col
                        localparam int N_IN = (c < `SA_LEN_TR) ? c + 1 : `SA_LEN_TR;

                        prod_t sel;

                        always_comb begin
                                sel = '0;
                                for (int k = 0; k < N_IN; k++) begin
                                        if (tr_sel_q == tr_sel_t'(k)) begin
                                                sel = prod_i[c-k];
                                        end
                                end
                        end

                        assign tr_o[c] = sel;
                end
        endgenerate

endmodule

// ==== sim/tb_sa_top.sv ====
`timescale 1ns/1ps
`include "sa_defs.svh"

module tb_sa_top
        import sa_pkg::*;
;

        localparam int MAX_CYCLES = 2000;
        localparam int SEL_ZERO   = 0;
        localparam int SEL_LADDER = 1;
        localparam int SEL_RANDOM = 2;

        typedef logic [`SA_ROWS-1:0] row_mask_t;
        // one expected result vector, column 0 in the low bits
        typedef logic [`SA_COLS*`SA_ACC_W-1:0] res_vec_t;

        logic     clk_i;
        logic     rst_n_i;
        logic     load_i;
        weight_t  weight_i [`SA_ROWS];
        logic     start_op_i;
        tr_sel_t  tr_sel_i [`SA_ROWS];
        logic     row_en_i [`SA_ROWS];
        logic     feature_valid_i;
        feature_t feature_i [`SA_ROWS];
        logic     weights_ready_o;
        logic     result_valid_o;
        acc_t     result_o [`SA_COLS];

        integer seed;
        int     value_errs = 0;
        int     other_errs = 0;
        int     cycle_cnt = 0;

        // reference model state
        sa_state_e m_state;
        int        m_loads;
        weight_t   hist [`SA_COLS][`SA_ROWS];
        tr_sel_t   sel_m [`SA_ROWS];
        logic      en_m [`SA_ROWS];
        logic      exp_v1;
        logic      exp_v2;
        logic      exp_ready;
        acc_t      exp_result [`SA_COLS];
        res_vec_t  exp_q [$];

        sa_top dut_i (
                .clk_i           (clk_i),
                .rst_n_i         (rst_n_i),
                .load_i          (load_i),
                .weight_i        (weight_i),
                .start_op_i      (start_op_i),
                .tr_sel_i        (tr_sel_i),
                .row_en_i        (row_en_i),
                .feature_valid_i (feature_valid_i),
                .feature_i       (feature_i),
                .weights_ready_o (weights_ready_o),
                .result_valid_o  (result_valid_o),
                .result_o        (result_o)
        );

        always #5 clk_i = ~clk_i;

        ////////////////////
        // reference model
        ////////////////////

        // weight[r][c] is hist[c][r], newest load in hist[0]
        function automatic res_vec_t expected_results();
                res_vec_t v;
                int sum;
                int k;
                v = '0;
                for (int c = 0; c < `SA_COLS; c++) begin
                        sum = 0;
                        for (int r = 0; r < `SA_ROWS; r++) begin
                                k = int'(sel_m[r]);
                                // shifted past the left edge gives zero
                                if (en_m[r] && k <= c) begin
                                        sum += int'(hist[c-k][r]) * int'(feature_i[r]);
                                end
                        end
                        v[c*`SA_ACC_W +: `SA_ACC_W] = acc_t'(sum);
                end
                return v;
        endfunction

        assign exp_ready = (m_state == SA_READY) || (m_state == SA_RUN);

        always @(posedge clk_i or negedge rst_n_i) begin
                res_vec_t head;
                if (!rst_n_i) begin
                        m_state <= SA_IDLE;
                        m_loads <= 0;
                        exp_v1  <= 1'b0;
                        exp_v2  <= 1'b0;
                        exp_q.delete();
                        for (int r = 0; r < `SA_ROWS; r++) begin
                                sel_m[r] <= '0;
                                en_m[r]  <= 1'b0;
                                for (int c = 0; c < `SA_COLS; c++) begin
                                        hist[c][r] <= '0;
                                end
                        end
                        for (int c = 0; c < `SA_COLS; c++) begin
                                exp_result[c] <= '0;
                        end
                end else begin
                        exp_v2 <= exp_v1;
                        exp_v1 <= 1'b0;
                        // each result pulse retires the oldest expected vector
                        if (result_valid_o) begin
                                if (exp_q.size() == 0) begin
                                        other_errs++;
                                        $display("result pulse with no expected result queued");
                                end else begin
                                        void'(exp_q.pop_front());
                                end
                        end
                        if (feature_valid_i && m_state == SA_RUN) begin
                                exp_q.push_back(expected_results());
                                exp_v1 <= 1'b1;
                        end
                        // oldest vector is what the next pulse must show
                        if (exp_q.size() != 0) begin
                                head = exp_q[0];
                                for (int c = 0; c < `SA_COLS; c++) begin
                                        exp_result[c] <= head[c*`SA_ACC_W +: `SA_ACC_W];
                                end
                        end
                        if (load_i) begin
                                for (int r = 0; r < `SA_ROWS; r++) begin
                                        hist[0][r] <= weight_i[r];
                                        for (int c = 1; c < `SA_COLS; c++) begin
                                                hist[c][r] <= hist[c-1][r];
                                        end
                                end
                                if (m_state == SA_LOAD) begin
                                        m_loads <= m_loads + 1;
                                        if (m_loads + 1 == `SA_COLS) begin
                                                m_state <= SA_READY;
                                        end
                                end else begin
                                        // a fresh weight set, any run is abandoned
                                        m_loads <= 1;
                                        m_state <= SA_LOAD;
                                end
                        end else if (start_op_i && m_state == SA_READY) begin
                                sel_m   <= tr_sel_i;
                                en_m    <= row_en_i;
                                m_state <= SA_RUN;
                        end
                end
        end

        ////////////////////
        // checks
        ////////////////////

        a_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                weights_ready_o == exp_ready)
                else begin
                        value_errs++;
                        $display("Error: weights_ready_o = %h, expected %h",
                                 $sampled(weights_ready_o), $sampled(exp_ready));
                end

        a_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                result_valid_o == exp_v2)
                else begin
                        value_errs++;
                        $display("Error: result_valid_o = %h, expected %h",
                                 $sampled(result_valid_o), $sampled(exp_v2));
                end

        genvar gc;
        generate
                for (gc = 0; gc < `SA_COLS; gc = gc + 1) begin : g_chk
                        a_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                result_valid_o |-> result_o[gc] == exp_result[gc])
                                else begin
                                        value_errs++;
                                        $display("Error: result_o[%0d] = %h, expected %h", gc,
                                                 $sampled(result_o[gc]),
                                                 $sampled(exp_result[gc]));
                                end
                end
        endgenerate

        ////////////////////
        // stimulus tasks
        ////////////////////

        task automatic load_set(input int n);
                for (int i = 0; i < n; i++) begin
                        @(posedge clk_i);
                        load_i <= 1'b1;
                        for (int r = 0; r < `SA_ROWS; r++) begin
                                weight_i[r] <= weight_t'($random(seed));
                        end
                end
                @(posedge clk_i);
                load_i <= 1'b0;
        endtask

        task automatic start_run(input int sel_mode, input row_mask_t en_mask);
                @(posedge clk_i);
                start_op_i <= 1'b1;
                for (int r = 0; r < `SA_ROWS; r++) begin
                        row_en_i[r] <= en_mask[r];
                        case (sel_mode)
                                SEL_ZERO:   tr_sel_i[r] <= '0;
                                SEL_LADDER: tr_sel_i[r] <= tr_sel_t'(r % `SA_LEN_TR);
                                default:    tr_sel_i[r] <= tr_sel_t'($random(seed));
                        endcase
                end
                @(posedge clk_i);
                start_op_i <= 1'b0;
        endtask

        // gap of zero gives back-to-back strobes
        task automatic feature_burst(input int n, input int gap);
                for (int i = 0; i < n; i++) begin
                        @(posedge clk_i);
                        feature_valid_i <= 1'b1;
                        for (int r = 0; r < `SA_ROWS; r++) begin
                                feature_i[r] <= feature_t'($random(seed));
                        end
                        for (int g = 0; g < gap; g++) begin
                                @(posedge clk_i);
                                feature_valid_i <= 1'b0;
                        end
                end
                @(posedge clk_i);
                feature_valid_i <= 1'b0;
        endtask

        // model pipeline empty means every pulse is due by now
        task automatic wait_drain();
                while (exp_v1 || exp_v2) begin
                        @(posedge clk_i);
                end
                repeat (2) @(posedge clk_i);
        endtask

        ////////////////////
        // test sequence
        ////////////////////

        initial begin
                seed            = 44;
                clk_i           = 1'b0;
                rst_n_i         = 1'b0;
                load_i          = 1'b0;
                start_op_i      = 1'b0;
                feature_valid_i = 1'b0;
                for (int r = 0; r < `SA_ROWS; r++) begin
                        weight_i[r]  = '0;
                        tr_sel_i[r]  = '0;
                        row_en_i[r]  = 1'b0;
                        feature_i[r] = '0;
                end
                repeat (10) @(posedge clk_i);
                rst_n_i <= 1'b1;

                // nothing loaded yet, start and features go nowhere
                start_run(SEL_ZERO, '1);
                feature_burst(2, 1);

                // partial set, then the rest after a pause
                load_set(2);
                repeat (3) @(posedge clk_i);
                load_set(`SA_COLS - 2);

                // ready but not started
                feature_burst(2, 0);
                start_run(SEL_ZERO, '1);
                feature_burst(8, 1);
                wait_drain();

                // row r shifted by r columns
                load_set(`SA_COLS);
                start_run(SEL_LADDER, '1);
                feature_burst(10, 0);
                wait_drain();

                load_set(`SA_COLS);
                start_run(SEL_RANDOM, 4'b0101);
                feature_burst(8, 0);
                wait_drain();

                // reload in the middle of a run
                load_set(`SA_COLS);
                start_run(SEL_RANDOM, 4'b1110);
                feature_burst(4, 0);
                @(posedge clk_i);
                feature_valid_i <= 1'b1;
                load_i          <= 1'b1;
                for (int r = 0; r < `SA_ROWS; r++) begin
                        feature_i[r] <= feature_t'($random(seed));
                        weight_i[r]  <= weight_t'($random(seed));
                end
                @(posedge clk_i);
                feature_valid_i <= 1'b0;
                load_i          <= 1'b0;
                feature_burst(3, 1);
                load_set(`SA_COLS - 1);
                start_run(SEL_RANDOM, '1);
                feature_burst(6, 0);
                wait_drain();

                for (int i = 0; i < 3; i++) begin
                        load_set(`SA_COLS);
                        start_run(SEL_RANDOM, row_mask_t'($random(seed)));
                        feature_burst(6, i);
                        wait_drain();
                end

                if (exp_q.size() != 0) begin
                        other_errs++;
                        $display("%0d expected results never arrived", exp_q.size());
                end
                $display("errors: %0d value mismatches, %0d other failures",
                         value_errs, other_errs);
                if (value_errs == 0 && other_errs == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

        // guard against a stuck run
        always @(posedge clk_i) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt == MAX_CYCLES) begin
                        $display("run did not finish within %0d cycles", MAX_CYCLES);
                        $display("errors: %0d value mismatches, %0d other failures",
                                 value_errs, other_errs + 1);
                        $display("Simulation failed");
                        $finish;
                end
        end

endmodule

// ==== sources.f ====
+incdir+design
design/sa_pkg.sv
design/sa_ctrl.sv
design/sa_pe_row.sv
design/sa_transfer_mux.sv
design/sa_column_adder.sv
design/sa_top.sv
sim/tb_sa_top.sv
